// ==== source/oq_pkg.sv ====
package oq_pkg;

  //////////////////////////////////////////////////////////////////////
  // Element and count types
  //////////////////////////////////////////////////////////////////////

  localparam int unsigned ELEN = 64;
  typedef logic [ELEN-1:0] elen_t;

  // Element count of one command, 1 to 255
  localparam int unsigned VlWidth = 8;
  typedef logic [VlWidth-1:0] vl_t;

  //////////////////////////////////////////////////////////////////////
  // Encodings
  //////////////////////////////////////////////////////////////////////

  typedef enum logic [1:0] {
    CONV_NONE,
    CONV_SEXT32,
    CONV_ZEXT32
  } conv_op_e;

  // Consumer of the shared slide/address-generation queue
  typedef enum logic {
    TARGET_ALU_SLDU,
    TARGET_MFPU_ADDRGEN
  } target_fu_e;

  typedef enum logic [1:0] {
    Q_ALU_A         = 2'd0,
    Q_ALU_B         = 2'd1,
    Q_STORE         = 2'd2,
    Q_SLIDE_ADDRGEN = 2'd3
  } queue_id_e;

  localparam int unsigned NrQueues = 4;

  typedef struct packed {
    vl_t        vl;
    conv_op_e   conv;
    target_fu_e target;
  } operand_queue_cmd_t;

  // Default buffer depths
  localparam int unsigned AluDataDepth    = 5;
  localparam int unsigned StuDataDepth    = 2;
  localparam int unsigned SlideDataDepth  = 2;
  localparam int unsigned DefaultCmdDepth = 4;

endpackage

// ==== source/operand_stream_if.sv ====
// One converted operand stream from a queue towards its unit port
interface operand_stream_if;

  oq_pkg::elen_t      operand;
  oq_pkg::target_fu_e target;
  logic               valid;
  logic               ready;

  // Queue side
  modport producer (
    output operand,
    output target,
    output valid,
    input  ready
  );

  // Unit port side
  modport consumer (
    input  operand,
    input  target,
    input  valid,
    output ready
  );

endinterface

// ==== source/operand_data_buffer.sv ====
module operand_data_buffer #(
  parameter int unsigned DataBufDepth = 2
) (
  input  logic          clk_i,
  input  logic          rst_n_i,
  input  logic          flush_i,
  input  oq_pkg::elen_t operand_i,
  input  logic          operand_valid_i,
  input  logic          operand_issued_i,
  input  logic          pop_i,
  output logic          queue_ready_o,
  output oq_pkg::elen_t data_o,
  output logic          data_valid_o
);

  localparam int unsigned PtrWidth = (DataBufDepth > 1) ? $clog2(DataBufDepth) : 1;
  localparam int unsigned CntWidth = $clog2(DataBufDepth + 1);
  localparam logic [PtrWidth-1:0] LastSlot = PtrWidth'(DataBufDepth - 1);
  localparam logic [CntWidth:0] DepthCnt = (CntWidth + 1)'(DataBufDepth);

  oq_pkg::elen_t       mem_q [DataBufDepth];
  logic [PtrWidth-1:0] wr_ptr_q;
  logic [PtrWidth-1:0] rd_ptr_q;
  logic [CntWidth-1:0] occ_cnt_q;
  logic [CntWidth-1:0] issued_cnt_q;
  logic [CntWidth:0]   used_slots;
  logic                pop;

  //////////////////////////////////////////////////////////////////////
  // Head and credit
  //////////////////////////////////////////////////////////////////////

  assign data_o       = mem_q[rd_ptr_q];
  assign data_valid_o = (occ_cnt_q != '0);
  assign pop          = pop_i & data_valid_o;

  // Slots already filled plus slots promised to reads in flight
  assign used_slots    = {1'b0, occ_cnt_q} + {1'b0, issued_cnt_q};
  assign queue_ready_o = (used_slots < DepthCnt);

  //////////////////////////////////////////////////////////////////////
  // Storage
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk_i) begin
    if (operand_valid_i) begin
      mem_q[wr_ptr_q] <= operand_i;
    end
  end

  always_ff @(posedge clk_i) begin
    if (!rst_n_i || flush_i) begin
      wr_ptr_q     <= '0;
      rd_ptr_q     <= '0;
      occ_cnt_q    <= '0;
      issued_cnt_q <= '0;
    end else begin
      if (operand_valid_i) begin
        wr_ptr_q <= (wr_ptr_q == LastSlot) ? '0 : wr_ptr_q + PtrWidth'(1);
      end
      if (pop) begin
        rd_ptr_q <= (rd_ptr_q == LastSlot) ? '0 : rd_ptr_q + PtrWidth'(1);
      end

      case ({operand_valid_i, pop})
        2'b10:   occ_cnt_q <= occ_cnt_q + CntWidth'(1);
        2'b01:   occ_cnt_q <= occ_cnt_q - CntWidth'(1);
        default: occ_cnt_q <= occ_cnt_q;
      endcase

      // An arriving element turns one credit into an occupied slot
      case ({operand_issued_i, operand_valid_i})
        2'b10:   issued_cnt_q <= issued_cnt_q + CntWidth'(1);
        2'b01:   issued_cnt_q <= issued_cnt_q - CntWidth'(1);
        default: issued_cnt_q <= issued_cnt_q;
      endcase
    end
  end

endmodule

// ==== source/operand_queue.sv ====
module operand_queue #(
  parameter int unsigned DataBufDepth = 2,
  parameter int unsigned CmdBufDepth  = 4
) (
  input  logic                       clk_i,
  input  logic                       rst_n_i,
  input  logic                       flush_i,
  input  oq_pkg::elen_t              operand_i,
  input  logic                       operand_valid_i,
  input  logic                       operand_issued_i,
  output logic                       queue_ready_o,
  input  oq_pkg::operand_queue_cmd_t cmd_i,
  input  logic                       cmd_valid_i,
  operand_stream_if.producer         out
);

  localparam int unsigned CmdPtrWidth = (CmdBufDepth > 1) ? $clog2(CmdBufDepth) : 1;
  localparam int unsigned CmdCntWidth = $clog2(CmdBufDepth + 1);
  localparam logic [CmdPtrWidth-1:0] CmdLastSlot = CmdPtrWidth'(CmdBufDepth - 1);

  oq_pkg::elen_t              data_head;
  logic                       data_valid;
  logic                       transfer;

  oq_pkg::operand_queue_cmd_t cmd_mem_q [CmdBufDepth];
  logic [CmdPtrWidth-1:0]     cmd_wr_ptr_q;
  logic [CmdPtrWidth-1:0]     cmd_rd_ptr_q;
  logic [CmdCntWidth-1:0]     cmd_cnt_q;
  oq_pkg::operand_queue_cmd_t cmd_head;
  logic                       cmd_present;
  logic                       cmd_pop;

  oq_pkg::vl_t                elem_cnt_q;
  logic                       last_elem;

  operand_data_buffer #(
    .DataBufDepth(DataBufDepth)
  ) i_data_buffer (
    .clk_i           (clk_i           ),
    .rst_n_i         (rst_n_i         ),
    .flush_i         (flush_i         ),
    .operand_i       (operand_i       ),
    .operand_valid_i (operand_valid_i ),
    .operand_issued_i(operand_issued_i),
    .pop_i           (transfer        ),
    .queue_ready_o   (queue_ready_o   ),
    .data_o          (data_head       ),
    .data_valid_o    (data_valid      )
  );

  //////////////////////////////////////////////////////////////////////
  // Command buffer
  //////////////////////////////////////////////////////////////////////

  assign cmd_head    = cmd_mem_q[cmd_rd_ptr_q];
  assign cmd_present = (cmd_cnt_q != '0);

  always_ff @(posedge clk_i) begin
    if (cmd_valid_i) begin
      cmd_mem_q[cmd_wr_ptr_q] <= cmd_i;
    end
  end

  always_ff @(posedge clk_i) begin
    if (!rst_n_i || flush_i) begin
      cmd_wr_ptr_q <= '0;
      cmd_rd_ptr_q <= '0;
      cmd_cnt_q    <= '0;
    end else begin
      if (cmd_valid_i) begin
        cmd_wr_ptr_q <= (cmd_wr_ptr_q == CmdLastSlot) ? '0 : cmd_wr_ptr_q + CmdPtrWidth'(1);
      end
      if (cmd_pop) begin
        cmd_rd_ptr_q <= (cmd_rd_ptr_q == CmdLastSlot) ? '0 : cmd_rd_ptr_q + CmdPtrWidth'(1);
      end
      case ({cmd_valid_i, cmd_pop})
        2'b10:   cmd_cnt_q <= cmd_cnt_q + CmdCntWidth'(1);
        2'b01:   cmd_cnt_q <= cmd_cnt_q - CmdCntWidth'(1);
        default: cmd_cnt_q <= cmd_cnt_q;
      endcase
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Element counting and output
  //////////////////////////////////////////////////////////////////////

  assign transfer  = out.valid & out.ready;
  assign last_elem = (elem_cnt_q == cmd_head.vl - oq_pkg::vl_t'(1));
  assign cmd_pop   = transfer & last_elem;

  always_ff @(posedge clk_i) begin
    if (!rst_n_i || flush_i) begin
      elem_cnt_q <= '0;
    end else if (transfer) begin
      elem_cnt_q <= last_elem ? '0 : elem_cnt_q + oq_pkg::vl_t'(1);
    end
  end

  // Nothing leaves without a command telling how to convert it
  assign out.valid = data_valid & cmd_present;

  // With no command the shared port points at the slide unit
  assign out.target = cmd_present ? cmd_head.target : oq_pkg::TARGET_ALU_SLDU;

  always_comb begin
    case (cmd_head.conv)
      oq_pkg::CONV_SEXT32: out.operand = {{32{data_head[31]}}, data_head[31:0]};
      oq_pkg::CONV_ZEXT32: out.operand = {32'b0, data_head[31:0]};
      default:             out.operand = data_head;
    endcase
  end

endmodule

// ==== source/vfu_operand_ports.sv ====
module vfu_operand_ports (
  operand_stream_if.consumer        alu_a,
  operand_stream_if.consumer        alu_b,
  operand_stream_if.consumer        stu,
  operand_stream_if.consumer        sldu_addrgen,
  // ALU
  output oq_pkg::elen_t [1:0]       alu_operand_o,
  output logic [1:0]                alu_operand_valid_o,
  input  logic [1:0]                alu_operand_ready_i,
  // Store unit
  output oq_pkg::elen_t             stu_operand_o,
  output logic                      stu_operand_valid_o,
  input  logic                      stu_operand_ready_i,
  // Slide unit and address generation
  output oq_pkg::elen_t             sldu_addrgen_operand_o,
  output oq_pkg::target_fu_e        sldu_addrgen_operand_target_fu_o,
  output logic                      sldu_addrgen_operand_valid_o,
  input  logic                      sldu_operand_ready_i,
  input  logic                      addrgen_operand_ready_i
);

  logic sldu_ready_filtered;
  logic addrgen_ready_filtered;

  //////////////////////////////////////////////////////////////////////
  // ALU and store unit
  //////////////////////////////////////////////////////////////////////

  assign alu_operand_o[0]       = alu_a.operand;
  assign alu_operand_valid_o[0] = alu_a.valid;
  assign alu_a.ready            = alu_operand_ready_i[0];

  assign alu_operand_o[1]       = alu_b.operand;
  assign alu_operand_valid_o[1] = alu_b.valid;
  assign alu_b.ready            = alu_operand_ready_i[1];

  assign stu_operand_o       = stu.operand;
  assign stu_operand_valid_o = stu.valid;
  assign stu.ready           = stu_operand_ready_i;

  //////////////////////////////////////////////////////////////////////
  // Shared slide/address-generation port
  //////////////////////////////////////////////////////////////////////

  assign sldu_addrgen_operand_o           = sldu_addrgen.operand;
  assign sldu_addrgen_operand_target_fu_o = sldu_addrgen.target;
  assign sldu_addrgen_operand_valid_o     = sldu_addrgen.valid;

  // Only the unit the head command targets may pop the element,
  // a stray ready from the other unit is masked off
  assign sldu_ready_filtered =
    sldu_operand_ready_i & (sldu_addrgen.target == oq_pkg::TARGET_ALU_SLDU);
  assign addrgen_ready_filtered =
    addrgen_operand_ready_i & (sldu_addrgen.target == oq_pkg::TARGET_MFPU_ADDRGEN);

  assign sldu_addrgen.ready = sldu_ready_filtered | addrgen_ready_filtered;

endmodule

// ==== source/operand_queues_stage.sv ====
module operand_queues_stage #(
  parameter int unsigned AluDataDepth   = oq_pkg::AluDataDepth,
  parameter int unsigned StuDataDepth   = oq_pkg::StuDataDepth,
  parameter int unsigned SlideDataDepth = oq_pkg::SlideDataDepth,
  parameter int unsigned CmdBufDepth    = oq_pkg::DefaultCmdDepth
) (
  input  logic                                              clk_i,
  input  logic                                              rst_n_i,
  // Register file side
  input  oq_pkg::elen_t              [oq_pkg::NrQueues-1:0] operand_i,
  input  logic                       [oq_pkg::NrQueues-1:0] operand_valid_i,
  // Operand requester side
  input  logic                       [oq_pkg::NrQueues-1:0] operand_issued_i,
  output logic                       [oq_pkg::NrQueues-1:0] operand_queue_ready_o,
  input  oq_pkg::operand_queue_cmd_t [oq_pkg::NrQueues-1:0] operand_queue_cmd_i,
  input  logic                       [oq_pkg::NrQueues-1:0] operand_queue_cmd_valid_i,
  // ALU
  output oq_pkg::elen_t              [1:0]                  alu_operand_o,
  output logic                       [1:0]                  alu_operand_valid_o,
  input  logic                       [1:0]                  alu_operand_ready_i,
  // Store unit
  output oq_pkg::elen_t                                     stu_operand_o,
  output logic                                              stu_operand_valid_o,
  input  logic                                              stu_operand_ready_i,
  input  logic                                              stu_exception_flush_i,
  // Slide unit and address generation
  output oq_pkg::elen_t                                     sldu_addrgen_operand_o,
  output oq_pkg::target_fu_e                                sldu_addrgen_operand_target_fu_o,
  output logic                                              sldu_addrgen_operand_valid_o,
  input  logic                                              sldu_operand_ready_i,
  input  logic                                              addrgen_operand_ready_i
);

  operand_stream_if alu_a_stream ();
  operand_stream_if alu_b_stream ();
  operand_stream_if stu_stream ();
  operand_stream_if sldu_addrgen_stream ();

  //////////////////////////////////////////////////////////////////////
  // Operand queues
  //////////////////////////////////////////////////////////////////////

  operand_queue #(
    .DataBufDepth(AluDataDepth),
    .CmdBufDepth (CmdBufDepth )
  ) i_oq_alu_a (
    .clk_i           (clk_i                                     ),
    .rst_n_i         (rst_n_i                                   ),
    .flush_i         (1'b0                                      ),
    .operand_i       (operand_i[oq_pkg::Q_ALU_A]                ),
    .operand_valid_i (operand_valid_i[oq_pkg::Q_ALU_A]          ),
    .operand_issued_i(operand_issued_i[oq_pkg::Q_ALU_A]         ),
    .queue_ready_o   (operand_queue_ready_o[oq_pkg::Q_ALU_A]    ),
    .cmd_i           (operand_queue_cmd_i[oq_pkg::Q_ALU_A]      ),
    .cmd_valid_i     (operand_queue_cmd_valid_i[oq_pkg::Q_ALU_A]),
    .out             (alu_a_stream                              )
  );

  operand_queue #(
    .DataBufDepth(AluDataDepth),
    .CmdBufDepth (CmdBufDepth )
  ) i_oq_alu_b (
    .clk_i           (clk_i                                     ),
    .rst_n_i         (rst_n_i                                   ),
    .flush_i         (1'b0                                      ),
    .operand_i       (operand_i[oq_pkg::Q_ALU_B]                ),
    .operand_valid_i (operand_valid_i[oq_pkg::Q_ALU_B]          ),
    .operand_issued_i(operand_issued_i[oq_pkg::Q_ALU_B]         ),
    .queue_ready_o   (operand_queue_ready_o[oq_pkg::Q_ALU_B]    ),
    .cmd_i           (operand_queue_cmd_i[oq_pkg::Q_ALU_B]      ),
    .cmd_valid_i     (operand_queue_cmd_valid_i[oq_pkg::Q_ALU_B]),
    .out             (alu_b_stream                              )
  );

  // The store queue alone is emptied on a store exception
  operand_queue #(
    .DataBufDepth(StuDataDepth),
    .CmdBufDepth (CmdBufDepth )
  ) i_oq_stu (
    .clk_i           (clk_i                                     ),
    .rst_n_i         (rst_n_i                                   ),
    .flush_i         (stu_exception_flush_i                     ),
    .operand_i       (operand_i[oq_pkg::Q_STORE]                ),
    .operand_valid_i (operand_valid_i[oq_pkg::Q_STORE]          ),
    .operand_issued_i(operand_issued_i[oq_pkg::Q_STORE]         ),
    .queue_ready_o   (operand_queue_ready_o[oq_pkg::Q_STORE]    ),
    .cmd_i           (operand_queue_cmd_i[oq_pkg::Q_STORE]      ),
    .cmd_valid_i     (operand_queue_cmd_valid_i[oq_pkg::Q_STORE]),
    .out             (stu_stream                                )
  );

  operand_queue #(
    .DataBufDepth(SlideDataDepth),
    .CmdBufDepth (CmdBufDepth   )
  ) i_oq_sldu_addrgen (
    .clk_i           (clk_i                                             ),
    .rst_n_i         (rst_n_i                                           ),
    .flush_i         (1'b0                                              ),
    .operand_i       (operand_i[oq_pkg::Q_SLIDE_ADDRGEN]                ),
    .operand_valid_i (operand_valid_i[oq_pkg::Q_SLIDE_ADDRGEN]          ),
    .operand_issued_i(operand_issued_i[oq_pkg::Q_SLIDE_ADDRGEN]         ),
    .queue_ready_o   (operand_queue_ready_o[oq_pkg::Q_SLIDE_ADDRGEN]    ),
    .cmd_i           (operand_queue_cmd_i[oq_pkg::Q_SLIDE_ADDRGEN]      ),
    .cmd_valid_i     (operand_queue_cmd_valid_i[oq_pkg::Q_SLIDE_ADDRGEN]),
    .out             (sldu_addrgen_stream                               )
  );

  //////////////////////////////////////////////////////////////////////
  // Unit ports
  //////////////////////////////////////////////////////////////////////

  vfu_operand_ports i_vfu_operand_ports (
    .alu_a                           (alu_a_stream                    ),
    .alu_b                           (alu_b_stream                    ),
    .stu                             (stu_stream                      ),
    .sldu_addrgen                    (sldu_addrgen_stream             ),
    .alu_operand_o                   (alu_operand_o                   ),
    .alu_operand_valid_o             (alu_operand_valid_o             ),
    .alu_operand_ready_i             (alu_operand_ready_i             ),
    .stu_operand_o                   (stu_operand_o                   ),
    .stu_operand_valid_o             (stu_operand_valid_o             ),
    .stu_operand_ready_i             (stu_operand_ready_i             ),
    .sldu_addrgen_operand_o          (sldu_addrgen_operand_o          ),
    .sldu_addrgen_operand_target_fu_o(sldu_addrgen_operand_target_fu_o),
    .sldu_addrgen_operand_valid_o    (sldu_addrgen_operand_valid_o    ),
    .sldu_operand_ready_i            (sldu_operand_ready_i            ),
    .addrgen_operand_ready_i         (addrgen_operand_ready_i         )
  );

endmodule

// ==== testbench/tb_utils.svh ====
`ifndef TB_UTILS_SVH
`define TB_UTILS_SVH

//////////////////////////////////////////////////////////////////////
// Random numbers
//////////////////////////////////////////////////////////////////////

logic [31:0] lcg_state = 32'd96502;

// Classic 32-bit LCG step
function automatic logic [31:0] lcg_next();
  lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
  return lcg_state;
endfunction

// Upper bits only, the low ones repeat too quickly
function automatic int random_below(input int unsigned bound);
  return int'((lcg_next() >> 16) % bound);
endfunction

function automatic oq_pkg::conv_op_e random_conv();
  oq_pkg::conv_op_e result;
  case (random_below(3))
    0:       result = oq_pkg::CONV_NONE;
    1:       result = oq_pkg::CONV_SEXT32;
    default: result = oq_pkg::CONV_ZEXT32;
  endcase
  return result;
endfunction

//////////////////////////////////////////////////////////////////////
// Reference model and comparison
//////////////////////////////////////////////////////////////////////

function automatic oq_pkg::elen_t conv_ref(input oq_pkg::elen_t value,
                                           input oq_pkg::conv_op_e conv);
  oq_pkg::elen_t low_word;
  oq_pkg::elen_t result;
  low_word = value & 64'h0000_0000_ffff_ffff;
  result   = value;
  if (conv == oq_pkg::CONV_ZEXT32) begin
    result = low_word;
  end else if (conv == oq_pkg::CONV_SEXT32) begin
    // Bit 31 fills the upper half
    result = value[31] ? (low_word | 64'hffff_ffff_0000_0000) : low_word;
  end
  return result;
endfunction

task automatic check_value(input string name, input logic [63:0] expected,
                           input logic [63:0] actual);
  if (actual !== expected) begin
    $display("Error in %s: expected %h, actual %h", name, expected, actual);
    stop_on_failure();
  end
endtask

`endif

// ==== testbench/tb_operand_queues_stage.sv ====
module tb_operand_queues_stage;

  localparam int Timeout    = 200;
  localparam int AluDepth   = 5;
  localparam int StuDepth   = 2;
  localparam int SlideDepth = 2;
  localparam int CmdDepth   = 4;

  logic                                              clk_i;
  logic                                              rst_n_i;
  oq_pkg::elen_t              [oq_pkg::NrQueues-1:0] operand_i;
  logic                       [oq_pkg::NrQueues-1:0] operand_valid_i;
  logic                       [oq_pkg::NrQueues-1:0] operand_issued_i;
  logic                       [oq_pkg::NrQueues-1:0] operand_queue_ready_o;
  oq_pkg::operand_queue_cmd_t [oq_pkg::NrQueues-1:0] operand_queue_cmd_i;
  logic                       [oq_pkg::NrQueues-1:0] operand_queue_cmd_valid_i;
  oq_pkg::elen_t              [1:0]                  alu_operand_o;
  logic                       [1:0]                  alu_operand_valid_o;
  logic                       [1:0]                  alu_operand_ready_i;
  oq_pkg::elen_t                                     stu_operand_o;
  logic                                              stu_operand_valid_o;
  logic                                              stu_operand_ready_i;
  logic                                              stu_exception_flush_i;
  oq_pkg::elen_t                                     sldu_addrgen_operand_o;
  oq_pkg::target_fu_e                                sldu_addrgen_operand_target_fu_o;
  logic                                              sldu_addrgen_operand_valid_o;
  logic                                              sldu_operand_ready_i;
  logic                                              addrgen_operand_ready_i;

  // Expected converted elements per queue, and targets of the shared queue
  oq_pkg::elen_t      exp_q [oq_pkg::NrQueues][$];
  oq_pkg::target_fu_e exp_tgt [$];

  `include "tb_utils.svh"

  operand_queues_stage #(
    .AluDataDepth  (AluDepth  ),
    .StuDataDepth  (StuDepth  ),
    .SlideDataDepth(SlideDepth),
    .CmdBufDepth   (CmdDepth  )
  ) operand_queues_stage_i (
    .clk_i                           (clk_i                           ),
    .rst_n_i                         (rst_n_i                         ),
    .operand_i                       (operand_i                       ),
    .operand_valid_i                 (operand_valid_i                 ),
    .operand_issued_i                (operand_issued_i                ),
    .operand_queue_ready_o           (operand_queue_ready_o           ),
    .operand_queue_cmd_i             (operand_queue_cmd_i             ),
    .operand_queue_cmd_valid_i       (operand_queue_cmd_valid_i       ),
    .alu_operand_o                   (alu_operand_o                   ),
    .alu_operand_valid_o             (alu_operand_valid_o             ),
    .alu_operand_ready_i             (alu_operand_ready_i             ),
    .stu_operand_o                   (stu_operand_o                   ),
    .stu_operand_valid_o             (stu_operand_valid_o             ),
    .stu_operand_ready_i             (stu_operand_ready_i             ),
    .stu_exception_flush_i           (stu_exception_flush_i           ),
    .sldu_addrgen_operand_o          (sldu_addrgen_operand_o          ),
    .sldu_addrgen_operand_target_fu_o(sldu_addrgen_operand_target_fu_o),
    .sldu_addrgen_operand_valid_o    (sldu_addrgen_operand_valid_o    ),
    .sldu_operand_ready_i            (sldu_operand_ready_i            ),
    .addrgen_operand_ready_i         (addrgen_operand_ready_i         )
  );

  initial begin
    clk_i = 1'b0;
    forever #2 clk_i = ~clk_i;
  end

  task automatic stop_on_failure();
    $display("Some tests failed");
    $fatal(1, "Simulation stopped at the first failure");
  endtask

  // Inputs change 1 unit after the rising edge
  task automatic next_cycle();
    @(posedge clk_i);
    #1;
  endtask

  //////////////////////////////////////////////////////////////////////
  // Requester side
  //////////////////////////////////////////////////////////////////////

  task automatic wait_for_credit(input oq_pkg::queue_id_e q);
    int cycles;
    cycles = 0;
    while (!operand_queue_ready_o[q]) begin
      if (cycles == Timeout) begin
        $display("Timeout waiting for credit on queue %s", q.name());
        stop_on_failure();
      end else begin
        next_cycle();
        cycles++;
      end
    end
  endtask

  task automatic wait_until_drained(input oq_pkg::queue_id_e q);
    int cycles;
    cycles = 0;
    while (exp_q[q].size() != 0) begin
      if (cycles == Timeout) begin
        $display("Timeout: queue %s still holds %0d elements", q.name(), exp_q[q].size());
        stop_on_failure();
      end else begin
        next_cycle();
        cycles++;
      end
    end
  endtask

  task automatic write_command(input oq_pkg::queue_id_e q, input int vl,
                               input oq_pkg::conv_op_e conv, input oq_pkg::target_fu_e tgt);
    operand_queue_cmd_i[q] = oq_pkg::operand_queue_cmd_t'{
      vl: oq_pkg::vl_t'(vl), conv: conv, target: tgt};
    operand_queue_cmd_valid_i[q] = 1'b1;
    next_cycle();
    operand_queue_cmd_valid_i[q] = 1'b0;
  endtask

  // One read at a time with its data arriving 1 to 3 cycles after the issue
  task automatic deliver_operands(input oq_pkg::queue_id_e q, input int n,
                                  input oq_pkg::conv_op_e conv, input oq_pkg::target_fu_e tgt);
    oq_pkg::elen_t value;
    int            delay;
    for (int i = 0; i < n; i++) begin
      wait_for_credit(q);
      value = {lcg_next(), lcg_next()};
      delay = random_below(3) + 1;
      operand_issued_i[q] = 1'b1;
      next_cycle();
      operand_issued_i[q] = 1'b0;
      repeat (delay - 1) next_cycle();
      operand_i[q]       = value;
      operand_valid_i[q] = 1'b1;
      exp_q[q].push_back(conv_ref(value, conv));
      if (q == oq_pkg::Q_SLIDE_ADDRGEN) begin
        exp_tgt.push_back(tgt);
      end
      next_cycle();
      operand_valid_i[q] = 1'b0;
    end
  endtask

  task automatic run_random_commands(input oq_pkg::queue_id_e q, input int count);
    int               vl;
    oq_pkg::conv_op_e conv;
    for (int k = 0; k < count; k++) begin
      vl   = random_below(6) + 1;
      conv = random_conv();
      write_command(q, vl, conv, oq_pkg::TARGET_ALU_SLDU);
      deliver_operands(q, vl, conv, oq_pkg::TARGET_ALU_SLDU);
    end
  endtask

  task automatic check_shared_routing(input oq_pkg::target_fu_e tgt);
    sldu_operand_ready_i    = 1'b0;
    addrgen_operand_ready_i = 1'b0;
    write_command(oq_pkg::Q_SLIDE_ADDRGEN, 1, oq_pkg::CONV_SEXT32, tgt);
    deliver_operands(oq_pkg::Q_SLIDE_ADDRGEN, 1, oq_pkg::CONV_SEXT32, tgt);
    check_value("shared_valid", 64'd1, 64'(sldu_addrgen_operand_valid_o));
    check_value("shared_target", 64'(tgt), 64'(sldu_addrgen_operand_target_fu_o));
    // Only the other unit says ready
    if (tgt == oq_pkg::TARGET_ALU_SLDU) begin
      addrgen_operand_ready_i = 1'b1;
    end else begin
      sldu_operand_ready_i = 1'b1;
    end
    repeat (10) next_cycle();
    check_value("shared_held_valid", 64'd1, 64'(sldu_addrgen_operand_valid_o));
    check_value("shared_held_data", exp_q[oq_pkg::Q_SLIDE_ADDRGEN][0],
                sldu_addrgen_operand_o);
    sldu_operand_ready_i    = (tgt == oq_pkg::TARGET_ALU_SLDU);
    addrgen_operand_ready_i = (tgt == oq_pkg::TARGET_MFPU_ADDRGEN);
    wait_until_drained(oq_pkg::Q_SLIDE_ADDRGEN);
    sldu_operand_ready_i    = 1'b0;
    addrgen_operand_ready_i = 1'b0;
  endtask

  //////////////////////////////////////////////////////////////////////
  // Checking process
  //////////////////////////////////////////////////////////////////////

  task automatic consume_transfer(input oq_pkg::queue_id_e q, input oq_pkg::elen_t actual);
    if (exp_q[q].size() == 0) begin
      $display("Queue %s handed out an element that was never delivered", q.name());
      stop_on_failure();
    end else begin
      check_value(q.name(), exp_q[q].pop_front(), actual);
    end
  endtask

  // Outputs are stable at the falling edge and a transfer follows at the next rising one
  always @(negedge clk_i) begin
    if (rst_n_i) begin
      if (alu_operand_valid_o[0] && alu_operand_ready_i[0]) begin
        consume_transfer(oq_pkg::Q_ALU_A, alu_operand_o[0]);
      end
      if (alu_operand_valid_o[1] && alu_operand_ready_i[1]) begin
        consume_transfer(oq_pkg::Q_ALU_B, alu_operand_o[1]);
      end
      if (stu_operand_valid_o && stu_operand_ready_i) begin
        consume_transfer(oq_pkg::Q_STORE, stu_operand_o);
      end
      if (sldu_addrgen_operand_valid_o &&
          ((sldu_addrgen_operand_target_fu_o == oq_pkg::TARGET_ALU_SLDU) ?
           sldu_operand_ready_i : addrgen_operand_ready_i)) begin
        if (exp_tgt.size() != 0) begin
          check_value("shared_target_at_transfer", 64'(exp_tgt.pop_front()),
                      64'(sldu_addrgen_operand_target_fu_o));
        end
        consume_transfer(oq_pkg::Q_SLIDE_ADDRGEN, sldu_addrgen_operand_o);
      end
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Test sequence
  //////////////////////////////////////////////////////////////////////

  initial begin
    rst_n_i                   = 1'b0;
    operand_i                 = '0;
    operand_valid_i           = '0;
    operand_issued_i          = '0;
    operand_queue_cmd_i       = '0;
    operand_queue_cmd_valid_i = '0;
    alu_operand_ready_i       = '0;
    stu_operand_ready_i       = 1'b0;
    stu_exception_flush_i     = 1'b0;
    sldu_operand_ready_i      = 1'b0;
    addrgen_operand_ready_i   = 1'b0;
    repeat (2) next_cycle();
    rst_n_i = 1'b1;

    check_value("reset_alu_valid", 64'd0, 64'(alu_operand_valid_o));
    check_value("reset_stu_valid", 64'd0, 64'(stu_operand_valid_o));
    check_value("reset_shared_valid", 64'd0, 64'(sldu_addrgen_operand_valid_o));
    check_value("reset_queue_ready", 64'hf, 64'(operand_queue_ready_o));
    check_value("reset_shared_target", 64'(oq_pkg::TARGET_ALU_SLDU),
                64'(sldu_addrgen_operand_target_fu_o));

    // Both ALU operands over several commands
    alu_operand_ready_i = 2'b11;
    fork
      run_random_commands(oq_pkg::Q_ALU_A, 3);
      run_random_commands(oq_pkg::Q_ALU_B, 3);
    join
    wait_until_drained(oq_pkg::Q_ALU_A);
    wait_until_drained(oq_pkg::Q_ALU_B);

    // Back-pressure on ALU operand A
    alu_operand_ready_i = 2'b00;
    write_command(oq_pkg::Q_ALU_A, 8, oq_pkg::CONV_SEXT32, oq_pkg::TARGET_ALU_SLDU);
    deliver_operands(oq_pkg::Q_ALU_A, AluDepth, oq_pkg::CONV_SEXT32, oq_pkg::TARGET_ALU_SLDU);
    check_value("alu_a_ready_when_full", 64'd0, 64'(operand_queue_ready_o[oq_pkg::Q_ALU_A]));
    check_value("alu_a_valid_when_full", 64'd1, 64'(alu_operand_valid_o[0]));
    alu_operand_ready_i = 2'b11;
    deliver_operands(oq_pkg::Q_ALU_A, 8 - AluDepth, oq_pkg::CONV_SEXT32,
                     oq_pkg::TARGET_ALU_SLDU);
    wait_until_drained(oq_pkg::Q_ALU_A);

    // Back-pressure on the store queue
    write_command(oq_pkg::Q_STORE, 4, oq_pkg::CONV_ZEXT32, oq_pkg::TARGET_ALU_SLDU);
    deliver_operands(oq_pkg::Q_STORE, StuDepth, oq_pkg::CONV_ZEXT32, oq_pkg::TARGET_ALU_SLDU);
    check_value("stu_ready_when_full", 64'd0, 64'(operand_queue_ready_o[oq_pkg::Q_STORE]));
    stu_operand_ready_i = 1'b1;
    deliver_operands(oq_pkg::Q_STORE, 4 - StuDepth, oq_pkg::CONV_ZEXT32,
                     oq_pkg::TARGET_ALU_SLDU);
    wait_until_drained(oq_pkg::Q_STORE);

    check_shared_routing(oq_pkg::TARGET_ALU_SLDU);
    check_shared_routing(oq_pkg::TARGET_MFPU_ADDRGEN);

    // Store exception flush with two buffered elements
    stu_operand_ready_i = 1'b0;
    write_command(oq_pkg::Q_STORE, 2, oq_pkg::CONV_NONE, oq_pkg::TARGET_ALU_SLDU);
    deliver_operands(oq_pkg::Q_STORE, StuDepth, oq_pkg::CONV_NONE, oq_pkg::TARGET_ALU_SLDU);
    check_value("stu_valid_before_flush", 64'd1, 64'(stu_operand_valid_o));
    stu_exception_flush_i = 1'b1;
    next_cycle();
    stu_exception_flush_i = 1'b0;
    exp_q[oq_pkg::Q_STORE].delete();
    check_value("stu_valid_after_flush", 64'd0, 64'(stu_operand_valid_o));
    check_value("stu_ready_after_flush", 64'd1, 64'(operand_queue_ready_o[oq_pkg::Q_STORE]));
    stu_operand_ready_i = 1'b1;
    write_command(oq_pkg::Q_STORE, 3, oq_pkg::CONV_SEXT32, oq_pkg::TARGET_ALU_SLDU);
    deliver_operands(oq_pkg::Q_STORE, 3, oq_pkg::CONV_SEXT32, oq_pkg::TARGET_ALU_SLDU);
    wait_until_drained(oq_pkg::Q_STORE);

    $display("All tests passed");
    $finish;
  end

endmodule

// ==== sources.f ====
+incdir+testbench
source/oq_pkg.sv
source/operand_stream_if.sv
source/operand_data_buffer.sv
source/operand_queue.sv
source/vfu_operand_ports.sv
source/operand_queues_stage.sv
testbench/tb_operand_queues_stage.sv

// ==== Makefile ====
TOP = tb_operand_queues_stage

.PHONY: sim clean

# The log decides the result, the simulator exit status does not
sim:
	verilator --binary --timing -j 0 -f sources.f --top-module $(TOP)
	./obj_dir/V$(TOP) > sim.log 2>&1 || true
	cat sim.log
	! grep -q "Some tests failed" sim.log
	grep -q "All tests passed" sim.log

clean:
	rm -rf obj_dir sim.log
